//--- jtag_debug.f
common/jtag_pkg.sv
common/debug_reg_pkg.sv
tap/tap_controller.sv
tap/dr_scan_chain.sv
source/debug_reg_file.sv
source/jtag_debug_top.sv
bench/jtag_debug_tb.sv

//--- Bender.yml
package:
  name: jtag_debug

sources:
  - files:
      - common/jtag_pkg.sv
      - common/debug_reg_pkg.sv
      - tap/tap_controller.sv
      - tap/dr_scan_chain.sv
      - source/debug_reg_file.sv
      - source/jtag_debug_top.sv
  - target: test
    files:
      - bench/jtag_debug_tb.sv

//--- bench/jtag_debug_tb.sv
`timescale 1ns/10ps

module jtag_debug_tb;

	localparam int CLK_PER_TCK = 8;
	// About 1540 tck cycles over all tests, doubled for margin
	localparam int SCAN_TCK_CYCLES = 1540;
	localparam int TIMEOUT_CYCLES  = SCAN_TCK_CYCLES * CLK_PER_TCK * 2;

	logic clk;
	logic rst_i;
	logic tck_i;
	logic tms_i;
	logic tdi_i;
	logic trst_n_i;
	logic tdo_o;

	debug_reg_pkg::cdr_status_t  cdr_status_i;
	debug_reg_pkg::prbs_status_t prbs_status_i;
	debug_reg_pkg::block_rst_t   block_rst_o;
	debug_reg_pkg::ibuf_cfg_t    ibuf_cfg_o;
	debug_reg_pkg::cdr_cfg_t     cdr_cfg_o;
	debug_reg_pkg::prbs_cfg_t    prbs_cfg_o;

	// Expected register contents
	debug_reg_pkg::block_rst_t exp_rst;
	debug_reg_pkg::ibuf_cfg_t  exp_ibuf;
	debug_reg_pkg::cdr_cfg_t   exp_cdr;
	debug_reg_pkg::prbs_cfg_t  exp_prbs;
	debug_reg_pkg::reg_addr_t  exp_addr;

	integer seed;
	int     error_count;
	int     check_count;
	int     test_count;
	int     errors_at_start;
	int     cycle_count;

	jtag_debug_top i_jtag_debug_top (
		.clk           (clk),
		.rst_i         (rst_i),
		.tck_i         (tck_i),
		.tms_i         (tms_i),
		.tdi_i         (tdi_i),
		.trst_n_i      (trst_n_i),
		.tdo_o         (tdo_o),
		.cdr_status_i  (cdr_status_i),
		.prbs_status_i (prbs_status_i),
		.block_rst_o   (block_rst_o),
		.ibuf_cfg_o    (ibuf_cfg_o),
		.cdr_cfg_o     (cdr_cfg_o),
		.prbs_cfg_o    (prbs_cfg_o)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout: run did not finish within %0d clk cycles", TIMEOUT_CYCLES);
		$display("ERRORS FOUND");
		$finish;
	end

	task automatic compare_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
		end
	endtask

	task automatic check_word(input string name, input debug_reg_pkg::reg_word_t got,
		input debug_reg_pkg::reg_word_t exp);
		compare_value(name, got, exp);
	endtask

	task automatic check_rst(input debug_reg_pkg::block_rst_t got,
		input debug_reg_pkg::block_rst_t exp);
		compare_value("block_rst_o", got, exp);
	endtask

	task automatic check_ibuf(input debug_reg_pkg::ibuf_cfg_t got,
		input debug_reg_pkg::ibuf_cfg_t exp);
		compare_value("ibuf_cfg_o", got, exp);
	endtask

	task automatic check_cdr_cfg(input debug_reg_pkg::cdr_cfg_t got,
		input debug_reg_pkg::cdr_cfg_t exp);
		compare_value("cdr_cfg_o.ki", got.ki, exp.ki);
		compare_value("cdr_cfg_o.kp", got.kp, exp.kp);
		compare_value("cdr_cfg_o.kr", got.kr, exp.kr);
		compare_value("cdr_cfg_o.en_ext_pi_ctl", got.en_ext_pi_ctl, exp.en_ext_pi_ctl);
		compare_value("cdr_cfg_o.ext_pi_ctl", got.ext_pi_ctl, exp.ext_pi_ctl);
	endtask

	task automatic check_prbs_cfg(input debug_reg_pkg::prbs_cfg_t got,
		input debug_reg_pkg::prbs_cfg_t exp);
		compare_value("prbs_cfg_o.cke", got.cke, exp.cke);
		compare_value("prbs_cfg_o.chan_sel", got.chan_sel, exp.chan_sel);
		compare_value("prbs_cfg_o.checker_mode", got.checker_mode, exp.checker_mode);
		compare_value("prbs_cfg_o.eqn", got.eqn, exp.eqn);
	endtask

	task automatic check_outputs();
		check_rst(block_rst_o, exp_rst);
		check_ibuf(ibuf_cfg_o, exp_ibuf);
		check_cdr_cfg(cdr_cfg_o, exp_cdr);
		check_prbs_cfg(prbs_cfg_o, exp_prbs);
	endtask

	task automatic reset_model();
		exp_rst  = '1;
		exp_ibuf = '0;
		exp_cdr  = '0;
		exp_prbs = '0;
		exp_addr = '0;
	endtask

	// Register bit layout of the debug map
	task automatic apply_write(input debug_reg_pkg::reg_addr_t addr,
		input debug_reg_pkg::reg_word_t w);
		case (addr)
			debug_reg_pkg::ADDR_CTRL: begin
				exp_rst.int_rst      = w[0];
				exp_rst.cdr_rst      = w[1];
				exp_rst.prbs_rst     = w[2];
				exp_rst.prbs_gen_rst = w[3];
			end
			debug_reg_pkg::ADDR_IBUF: begin
				exp_ibuf.disable_async    = w[0];
				exp_ibuf.disable_main     = w[1];
				exp_ibuf.disable_mdll_ref = w[2];
				exp_ibuf.disable_mdll_mon = w[3];
			end
			debug_reg_pkg::ADDR_CDR_GAIN: begin
				exp_cdr.ki = w[3:0];
				exp_cdr.kp = w[7:4];
				exp_cdr.kr = w[11:8];
			end
			debug_reg_pkg::ADDR_CDR_PI: begin
				exp_cdr.en_ext_pi_ctl = w[0];
				exp_cdr.ext_pi_ctl    = w[9:1];
			end
			debug_reg_pkg::ADDR_PRBS_CFG: begin
				exp_prbs.cke          = w[0];
				exp_prbs.chan_sel     = w[4:1];
				exp_prbs.checker_mode = w[6:5];
			end
			debug_reg_pkg::ADDR_PRBS_EQN: exp_prbs.eqn = w;
			default: begin
			end
		endcase
	endtask

	function automatic debug_reg_pkg::reg_word_t defined_mask(
		input debug_reg_pkg::reg_addr_t addr);
		case (addr)
			debug_reg_pkg::ADDR_CTRL,
			debug_reg_pkg::ADDR_IBUF:     return 32'h0000_000F;
			debug_reg_pkg::ADDR_CDR_GAIN: return 32'h0000_0FFF;
			debug_reg_pkg::ADDR_CDR_PI:   return 32'h0000_03FF;
			debug_reg_pkg::ADDR_PRBS_CFG: return 32'h0000_007F;
			debug_reg_pkg::ADDR_PRBS_EQN: return 32'hFFFF_FFFF;
			default:                      return '0;
		endcase
	endfunction

	// TDO is sampled at the end of the low phase, just before tck rises
	task automatic tck_cycle(input logic tms, input logic tdi, output logic tdo);
		tck_i = 1'b0;
		tms_i = tms;
		tdi_i = tdi;
		repeat (CLK_PER_TCK / 2) @(negedge clk);
		tdo   = tdo_o;
		tck_i = 1'b1;
		repeat (CLK_PER_TCK / 2) @(negedge clk);
	endtask

	task automatic goto_reset();
		logic unused;
		repeat (5) tck_cycle(1'b1, 1'b0, unused);
	endtask

	task automatic scan_ir(input jtag_pkg::jtag_instr_e instr,
		output logic [jtag_pkg::IR_WIDTH-1:0] ir_out);
		logic unused;
		logic bit_out;
		int   i;
		// From Test-Logic-Reset or Idle through Select-DR, Select-IR, Capture-IR
		tck_cycle(1'b0, 1'b0, unused);
		tck_cycle(1'b1, 1'b0, unused);
		tck_cycle(1'b1, 1'b0, unused);
		tck_cycle(1'b0, 1'b0, unused);
		tck_cycle(1'b0, 1'b0, unused);
		for (i = 0; i < jtag_pkg::IR_WIDTH; i++) begin
			tck_cycle(i == jtag_pkg::IR_WIDTH - 1, instr[i], bit_out);
			ir_out[i] = bit_out;
		end
		tck_cycle(1'b1, 1'b0, unused);
		tck_cycle(1'b0, 1'b0, unused);
	endtask

	task automatic scan_dr(input int len, input debug_reg_pkg::reg_word_t din,
		output debug_reg_pkg::reg_word_t dout);
		logic unused;
		logic bit_out;
		int   i;
		dout = '0;
		tck_cycle(1'b0, 1'b0, unused);
		tck_cycle(1'b1, 1'b0, unused);
		tck_cycle(1'b0, 1'b0, unused);
		tck_cycle(1'b0, 1'b0, unused);
		for (i = 0; i < len; i++) begin
			tck_cycle(i == len - 1, din[i], bit_out);
			dout[i] = bit_out;
		end
		tck_cycle(1'b1, 1'b0, unused);
		tck_cycle(1'b0, 1'b0, unused);
	endtask

	// The ADDR scan returns the address that was latched before
	task automatic set_address(input debug_reg_pkg::reg_addr_t addr);
		logic [jtag_pkg::IR_WIDTH-1:0] ir;
		debug_reg_pkg::reg_word_t      captured;
		scan_ir(jtag_pkg::ADDR, ir);
		scan_dr(debug_reg_pkg::ADDR_WIDTH, addr, captured);
		check_word("addr_dr", captured, exp_addr);
		exp_addr = addr;
	endtask

	task automatic access_reg(input debug_reg_pkg::reg_addr_t addr,
		input debug_reg_pkg::reg_word_t wdata, output debug_reg_pkg::reg_word_t rdata);
		logic [jtag_pkg::IR_WIDTH-1:0] ir;
		set_address(addr);
		scan_ir(jtag_pkg::DATA, ir);
		scan_dr(debug_reg_pkg::REG_WIDTH, wdata, rdata);
		apply_write(addr, wdata);
	endtask

	task automatic report_test(input string name);
		test_count++;
		if (error_count == errors_at_start) begin
			$display("%s: pass", name);
		end else begin
			$display("%s: fail, %0d mismatches", name, error_count - errors_at_start);
		end
	endtask

	task automatic idcode_after_reset();
		debug_reg_pkg::reg_word_t din;
		debug_reg_pkg::reg_word_t dout;
		errors_at_start = error_count;
		din = $random(seed);
		scan_dr(32, din, dout);
		check_word("idcode_dr", dout, jtag_pkg::IDCODE_VALUE);
		check_outputs();
		report_test("idcode_after_reset");
	endtask

	task automatic bypass_delay();
		logic [jtag_pkg::IR_WIDTH-1:0] ir;
		debug_reg_pkg::reg_word_t      pattern;
		debug_reg_pkg::reg_word_t      dout;
		errors_at_start = error_count;
		pattern = $random(seed);
		scan_ir(jtag_pkg::BYPASS, ir);
		check_word("ir_capture", ir, 32'h0000_0001);
		scan_dr(16, pattern, dout);
		check_word("bypass_dr", dout, {16'h0, pattern[14:0], 1'b0});
		check_outputs();
		report_test("bypass_delay");
	endtask

	task automatic register_writes();
		debug_reg_pkg::reg_addr_t addr;
		debug_reg_pkg::reg_word_t w;
		debug_reg_pkg::reg_word_t rd;
		int i;
		errors_at_start = error_count;
		// Writable registers sit at 0x00 to 0x05
		for (i = 0; i < 6; i++) begin
			addr = debug_reg_pkg::ADDR_CTRL + i;
			w    = $random(seed);
			access_reg(addr, w, rd);
			check_outputs();
			scan_dr(32, w, rd);
			check_word("data_dr", rd, w & defined_mask(addr));
			check_outputs();
		end
		report_test("register_writes");
	endtask

	task automatic status_readback();
		debug_reg_pkg::reg_word_t w;
		debug_reg_pkg::reg_word_t rd;
		errors_at_start = error_count;
		cdr_status_i.phase_est   = $random(seed);
		prbs_status_i.err_bits   = $random(seed);
		prbs_status_i.total_bits = $random(seed);
		w = $random(seed);
		access_reg(debug_reg_pkg::ADDR_CDR_PHASE, w, rd);
		check_word("cdr_phase_dr", rd, cdr_status_i.phase_est);
		access_reg(debug_reg_pkg::ADDR_PRBS_ERR, w, rd);
		check_word("prbs_err_dr", rd, prbs_status_i.err_bits);
		access_reg(debug_reg_pkg::ADDR_PRBS_TOTAL, w, rd);
		check_word("prbs_total_dr", rd, prbs_status_i.total_bits);
		check_outputs();
		report_test("status_readback");
	endtask

	task automatic ignored_writes();
		debug_reg_pkg::reg_word_t w;
		debug_reg_pkg::reg_word_t rd;
		errors_at_start = error_count;
		w = $random(seed);
		access_reg(debug_reg_pkg::ADDR_CDR_PHASE, w, rd);
		check_outputs();
		access_reg(8'h40, w, rd);
		check_word("unmapped_dr", rd, '0);
		scan_dr(32, w, rd);
		check_word("unmapped_dr", rd, '0);
		check_outputs();
		access_reg(debug_reg_pkg::ADDR_CTRL, '0, rd);
		check_rst(block_rst_o, '0);
		check_outputs();
		// Idle the pins low on tck before the reset pulse
		tck_i = 1'b0;
		tms_i = 1'b1;
		rst_i = 1'b1;
		repeat (3) @(negedge clk);
		rst_i = 1'b0;
		repeat (4) @(negedge clk);
		reset_model();
		check_rst(block_rst_o, '1);
		check_outputs();
		scan_dr(32, w, rd);
		check_word("idcode_dr", rd, jtag_pkg::IDCODE_VALUE);
		report_test("ignored_writes");
	endtask

	task automatic tap_reset_keeps_config();
		logic [jtag_pkg::IR_WIDTH-1:0] ir;
		debug_reg_pkg::reg_word_t      w;
		debug_reg_pkg::reg_word_t      rd;
		errors_at_start = error_count;
		w = $random(seed);
		access_reg(debug_reg_pkg::ADDR_CDR_GAIN, w, rd);
		w = $random(seed);
		access_reg(debug_reg_pkg::ADDR_PRBS_EQN, w, rd);
		goto_reset();
		scan_dr(32, w, rd);
		check_word("idcode_dr", rd, jtag_pkg::IDCODE_VALUE);
		check_outputs();
		scan_ir(jtag_pkg::DATA, ir);
		trst_n_i = 1'b0;
		repeat (4) @(negedge clk);
		trst_n_i = 1'b1;
		repeat (4) @(negedge clk);
		scan_dr(32, w, rd);
		check_word("idcode_dr", rd, jtag_pkg::IDCODE_VALUE);
		check_outputs();
		set_address(debug_reg_pkg::ADDR_CTRL);
		report_test("tap_reset_keeps_config");
	endtask

	initial begin
		seed          = 95593;
		error_count   = 0;
		check_count   = 0;
		test_count    = 0;
		rst_i         = 1'b1;
		tck_i         = 1'b0;
		tms_i         = 1'b1;
		tdi_i         = 1'b0;
		trst_n_i      = 1'b1;
		cdr_status_i  = '0;
		prbs_status_i = '0;
		reset_model();
		repeat (3) @(negedge clk);
		rst_i = 1'b0;
		repeat (4) @(negedge clk);

		idcode_after_reset();
		bypass_delay();
		register_writes();
		status_readback();
		ignored_writes();
		tap_reset_keeps_config();

		$display("Tests: %0d, checks: %0d, mismatches: %0d", test_count, check_count,
			error_count);
		if (error_count == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

//--- source/jtag_debug_top.sv
`timescale 1ns/10ps

module jtag_debug_top (
	input  logic                        clk,
	input  logic                        rst_i,
	input  logic                        tck_i,
	input  logic                        tms_i,
	input  logic                        tdi_i,
	input  logic                        trst_n_i,
	output logic                        tdo_o,
	input  debug_reg_pkg::cdr_status_t  cdr_status_i,
	input  debug_reg_pkg::prbs_status_t prbs_status_i,
	output debug_reg_pkg::block_rst_t   block_rst_o,
	output debug_reg_pkg::ibuf_cfg_t    ibuf_cfg_o,
	output debug_reg_pkg::cdr_cfg_t     cdr_cfg_o,
	output debug_reg_pkg::prbs_cfg_t    prbs_cfg_o
);

	jtag_pkg::tap_strobe_t     strobe;
	jtag_pkg::jtag_instr_e     instr;
	logic                      tdi_sync;
	logic                      dr_tdo;
	debug_reg_pkg::reg_addr_t  read_addr;
	debug_reg_pkg::reg_word_t  read_data;
	debug_reg_pkg::reg_write_t reg_write;

	tap_controller i_tap_controller (
		.clk      (clk),
		.rst_i    (rst_i),
		.tck_i    (tck_i),
		.tms_i    (tms_i),
		.tdi_i    (tdi_i),
		.trst_n_i (trst_n_i),
		.dr_tdo_i (dr_tdo),
		.strobe_o (strobe),
		.instr_o  (instr),
		.tdi_o    (tdi_sync),
		.tdo_o    (tdo_o)
	);

	dr_scan_chain i_dr_scan_chain (
		.clk         (clk),
		.rst_i       (rst_i),
		.strobe_i    (strobe),
		.instr_i     (instr),
		.tdi_i       (tdi_sync),
		.read_data_i (read_data),
		.dr_tdo_o    (dr_tdo),
		.read_addr_o (read_addr),
		.write_o     (reg_write)
	);

	debug_reg_file i_debug_reg_file (
		.clk           (clk),
		.rst_i         (rst_i),
		.read_addr_i   (read_addr),
		.write_i       (reg_write),
		.cdr_status_i  (cdr_status_i),
		.prbs_status_i (prbs_status_i),
		.read_data_o   (read_data),
		.block_rst_o   (block_rst_o),
		.ibuf_cfg_o    (ibuf_cfg_o),
		.cdr_cfg_o     (cdr_cfg_o),
		.prbs_cfg_o    (prbs_cfg_o)
	);

endmodule

//--- source/debug_reg_file.sv
`timescale 1ns/10ps

module debug_reg_file (
	input  logic                        clk,
	input  logic                        rst_i,
	input  debug_reg_pkg::reg_addr_t    read_addr_i,
	input  debug_reg_pkg::reg_write_t   write_i,
	input  debug_reg_pkg::cdr_status_t  cdr_status_i,
	input  debug_reg_pkg::prbs_status_t prbs_status_i,
	output debug_reg_pkg::reg_word_t    read_data_o,
	output debug_reg_pkg::block_rst_t   block_rst_o,
	output debug_reg_pkg::ibuf_cfg_t    ibuf_cfg_o,
	output debug_reg_pkg::cdr_cfg_t     cdr_cfg_o,
	output debug_reg_pkg::prbs_cfg_t    prbs_cfg_o
);

	debug_reg_pkg::block_rst_t ctrl_q;
	debug_reg_pkg::ibuf_cfg_t  ibuf_q;
	debug_reg_pkg::cdr_cfg_t   cdr_q;
	debug_reg_pkg::prbs_cfg_t  prbs_q;

	// Blocks come out of reset only after CTRL is cleared
	always_ff @(posedge clk) begin
		if (rst_i) begin
			ctrl_q <= '1;
			ibuf_q <= '0;
			cdr_q  <= '0;
			prbs_q <= '0;
		end else if (write_i.en) begin
			case (write_i.addr)
				debug_reg_pkg::ADDR_CTRL: begin
					ctrl_q.int_rst      <= write_i.data[0];
					ctrl_q.cdr_rst      <= write_i.data[1];
					ctrl_q.prbs_rst     <= write_i.data[2];
					ctrl_q.prbs_gen_rst <= write_i.data[3];
				end
				debug_reg_pkg::ADDR_IBUF: begin
					ibuf_q.disable_async    <= write_i.data[0];
					ibuf_q.disable_main     <= write_i.data[1];
					ibuf_q.disable_mdll_ref <= write_i.data[2];
					ibuf_q.disable_mdll_mon <= write_i.data[3];
				end
				debug_reg_pkg::ADDR_CDR_GAIN: begin
					cdr_q.ki <= write_i.data[debug_reg_pkg::KI_LSB +: debug_reg_pkg::GAIN_WIDTH];
					cdr_q.kp <= write_i.data[debug_reg_pkg::KP_LSB +: debug_reg_pkg::GAIN_WIDTH];
					cdr_q.kr <= write_i.data[debug_reg_pkg::KR_LSB +: debug_reg_pkg::GAIN_WIDTH];
				end
				debug_reg_pkg::ADDR_CDR_PI: begin
					cdr_q.en_ext_pi_ctl <= write_i.data[debug_reg_pkg::PI_EN_BIT];
					cdr_q.ext_pi_ctl    <=
						write_i.data[debug_reg_pkg::PI_CTL_LSB +: debug_reg_pkg::PI_CTL_WIDTH];
				end
				debug_reg_pkg::ADDR_PRBS_CFG: begin
					prbs_q.cke          <= write_i.data[debug_reg_pkg::PRBS_CKE_BIT];
					prbs_q.chan_sel     <=
						write_i.data[debug_reg_pkg::CHAN_SEL_LSB +: debug_reg_pkg::CHAN_SEL_WIDTH];
					prbs_q.checker_mode <= write_i.data[debug_reg_pkg::CHECKER_MODE_LSB +:
						debug_reg_pkg::CHECKER_MODE_WIDTH];
				end
				debug_reg_pkg::ADDR_PRBS_EQN: begin
					prbs_q.eqn <= write_i.data;
				end
				default: begin
					// status and unmapped addresses ignore writes
				end
			endcase
		end
	end

	always_comb begin
		read_data_o = '0;
		case (read_addr_i)
			debug_reg_pkg::ADDR_CTRL: begin
				read_data_o[3:0] = {ctrl_q.prbs_gen_rst, ctrl_q.prbs_rst,
					ctrl_q.cdr_rst, ctrl_q.int_rst};
			end
			debug_reg_pkg::ADDR_IBUF: begin
				read_data_o[3:0] = {ibuf_q.disable_mdll_mon, ibuf_q.disable_mdll_ref,
					ibuf_q.disable_main, ibuf_q.disable_async};
			end
			debug_reg_pkg::ADDR_CDR_GAIN: begin
				read_data_o[debug_reg_pkg::KI_LSB +: debug_reg_pkg::GAIN_WIDTH] = cdr_q.ki;
				read_data_o[debug_reg_pkg::KP_LSB +: debug_reg_pkg::GAIN_WIDTH] = cdr_q.kp;
				read_data_o[debug_reg_pkg::KR_LSB +: debug_reg_pkg::GAIN_WIDTH] = cdr_q.kr;
			end
			debug_reg_pkg::ADDR_CDR_PI: begin
				read_data_o[debug_reg_pkg::PI_EN_BIT] = cdr_q.en_ext_pi_ctl;
				read_data_o[debug_reg_pkg::PI_CTL_LSB +: debug_reg_pkg::PI_CTL_WIDTH] =
					cdr_q.ext_pi_ctl;
			end
			debug_reg_pkg::ADDR_PRBS_CFG: begin
				read_data_o[debug_reg_pkg::PRBS_CKE_BIT] = prbs_q.cke;
				read_data_o[debug_reg_pkg::CHAN_SEL_LSB +: debug_reg_pkg::CHAN_SEL_WIDTH] =
					prbs_q.chan_sel;
				read_data_o[debug_reg_pkg::CHECKER_MODE_LSB +:
					debug_reg_pkg::CHECKER_MODE_WIDTH] = prbs_q.checker_mode;
			end
			debug_reg_pkg::ADDR_PRBS_EQN:   read_data_o = prbs_q.eqn;
			debug_reg_pkg::ADDR_CDR_PHASE:  read_data_o = cdr_status_i.phase_est;
			debug_reg_pkg::ADDR_PRBS_ERR:   read_data_o = prbs_status_i.err_bits;
			debug_reg_pkg::ADDR_PRBS_TOTAL: read_data_o = prbs_status_i.total_bits;
			default:                        read_data_o = '0;
		endcase
	end

	assign block_rst_o = ctrl_q | debug_reg_pkg::block_rst_t'({4{rst_i}});
	assign ibuf_cfg_o  = ibuf_q;
	assign cdr_cfg_o   = cdr_q;
	assign prbs_cfg_o  = prbs_q;

endmodule

//--- tap/dr_scan_chain.sv
`timescale 1ns/10ps

module dr_scan_chain (
	input  logic                       clk,
	input  logic                       rst_i,
	input  jtag_pkg::tap_strobe_t      strobe_i,
	input  jtag_pkg::jtag_instr_e      instr_i,
	input  logic                       tdi_i,
	input  debug_reg_pkg::reg_word_t   read_data_i,
	output logic                       dr_tdo_o,
	output debug_reg_pkg::reg_addr_t   read_addr_o,
	output debug_reg_pkg::reg_write_t  write_o
);

	jtag_pkg::jtag_instr_e    dr_sel;
	debug_reg_pkg::reg_word_t dr_sr;
	debug_reg_pkg::reg_addr_t addr_q;

	// Unknown instructions fall back to BYPASS
	always_comb begin
		case (instr_i)
			jtag_pkg::IDCODE,
			jtag_pkg::ADDR,
			jtag_pkg::DATA: dr_sel = instr_i;
			default:        dr_sel = jtag_pkg::BYPASS;
		endcase
	end

	// One shift register serves all four DRs, the instruction picks the length
	always_ff @(posedge clk) begin
		if (strobe_i.dr_capture) begin
			case (dr_sel)
				jtag_pkg::IDCODE: dr_sr <= jtag_pkg::IDCODE_VALUE;
				jtag_pkg::ADDR:   dr_sr <= debug_reg_pkg::REG_WIDTH'(addr_q);
				jtag_pkg::DATA:   dr_sr <= read_data_i;
				default:          dr_sr <= '0;
			endcase
		end else if (strobe_i.dr_shift) begin
			case (dr_sel)
				jtag_pkg::ADDR: begin
					dr_sr[debug_reg_pkg::ADDR_WIDTH-1:0] <=
						{tdi_i, dr_sr[debug_reg_pkg::ADDR_WIDTH-1:1]};
				end
				jtag_pkg::IDCODE,
				jtag_pkg::DATA: begin
					dr_sr <= {tdi_i, dr_sr[debug_reg_pkg::REG_WIDTH-1:1]};
				end
				default: begin
					dr_sr[0] <= tdi_i;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			addr_q <= '0;
		end else if (strobe_i.dr_update && (dr_sel == jtag_pkg::ADDR)) begin
			addr_q <= dr_sr[debug_reg_pkg::ADDR_WIDTH-1:0];
		end
	end

	assign dr_tdo_o    = dr_sr[0];
	assign read_addr_o = addr_q;

	// Write goes out with the update strobe itself
	always_comb begin
		write_o.en   = strobe_i.dr_update && (dr_sel == jtag_pkg::DATA);
		write_o.addr = addr_q;
		write_o.data = dr_sr;
	end

endmodule

//--- tap/tap_controller.sv
`timescale 1ns/10ps

module tap_controller (
	input  logic                  clk,
	input  logic                  rst_i,
	input  logic                  tck_i,
	input  logic                  tms_i,
	input  logic                  tdi_i,
	input  logic                  trst_n_i,
	input  logic                  dr_tdo_i,
	output jtag_pkg::tap_strobe_t strobe_o,
	output jtag_pkg::jtag_instr_e instr_o,
	output logic                  tdi_o,
	output logic                  tdo_o
);

	// Pin order tck, tms, tdi, trst_n
	logic [3:0] pin_meta;
	logic [3:0] pin_sync;
	logic       tck_q;
	logic       tck_rise;
	logic       tck_fall;
	logic       tms;
	logic       trst_n;

	jtag_pkg::tap_state_e state_q;
	jtag_pkg::tap_state_e state_d;

	logic [jtag_pkg::IR_WIDTH-1:0] ir_sr;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			pin_meta <= '0;
			pin_sync <= '0;
			tck_q    <= 1'b0;
		end else begin
			pin_meta <= {tck_i, tms_i, tdi_i, trst_n_i};
			pin_sync <= pin_meta;
			tck_q    <= pin_sync[3];
		end
	end

	assign tms    = pin_sync[2];
	assign tdi_o  = pin_sync[1];
	assign trst_n = pin_sync[0];

	// tck is only sampled, edges come from the extra register
	assign tck_rise = pin_sync[3] & ~tck_q & trst_n;
	assign tck_fall = ~pin_sync[3] & tck_q;

	always_comb begin
		state_d = state_q;
		case (state_q)
			jtag_pkg::TAP_RESET:    state_d = tms ? jtag_pkg::TAP_RESET : jtag_pkg::TAP_IDLE;
			jtag_pkg::TAP_IDLE:     state_d = tms ? jtag_pkg::TAP_SEL_DR : jtag_pkg::TAP_IDLE;
			jtag_pkg::TAP_SEL_DR:   state_d = tms ? jtag_pkg::TAP_SEL_IR : jtag_pkg::TAP_CAP_DR;
			jtag_pkg::TAP_CAP_DR:   state_d = tms ? jtag_pkg::TAP_EXIT1_DR : jtag_pkg::TAP_SHIFT_DR;
			jtag_pkg::TAP_SHIFT_DR: state_d = tms ? jtag_pkg::TAP_EXIT1_DR : jtag_pkg::TAP_SHIFT_DR;
			jtag_pkg::TAP_EXIT1_DR: state_d = tms ? jtag_pkg::TAP_UPD_DR : jtag_pkg::TAP_PAUSE_DR;
			jtag_pkg::TAP_PAUSE_DR: state_d = tms ? jtag_pkg::TAP_EXIT2_DR : jtag_pkg::TAP_PAUSE_DR;
			jtag_pkg::TAP_EXIT2_DR: state_d = tms ? jtag_pkg::TAP_UPD_DR : jtag_pkg::TAP_SHIFT_DR;
			jtag_pkg::TAP_UPD_DR:   state_d = tms ? jtag_pkg::TAP_SEL_DR : jtag_pkg::TAP_IDLE;
			jtag_pkg::TAP_SEL_IR:   state_d = tms ? jtag_pkg::TAP_RESET : jtag_pkg::TAP_CAP_IR;
			jtag_pkg::TAP_CAP_IR:   state_d = tms ? jtag_pkg::TAP_EXIT1_IR : jtag_pkg::TAP_SHIFT_IR;
			jtag_pkg::TAP_SHIFT_IR: state_d = tms ? jtag_pkg::TAP_EXIT1_IR : jtag_pkg::TAP_SHIFT_IR;
			jtag_pkg::TAP_EXIT1_IR: state_d = tms ? jtag_pkg::TAP_UPD_IR : jtag_pkg::TAP_PAUSE_IR;
			jtag_pkg::TAP_PAUSE_IR: state_d = tms ? jtag_pkg::TAP_EXIT2_IR : jtag_pkg::TAP_PAUSE_IR;
			jtag_pkg::TAP_EXIT2_IR: state_d = tms ? jtag_pkg::TAP_UPD_IR : jtag_pkg::TAP_SHIFT_IR;
			jtag_pkg::TAP_UPD_IR:   state_d = tms ? jtag_pkg::TAP_SEL_DR : jtag_pkg::TAP_IDLE;
			default:                state_d = jtag_pkg::TAP_RESET;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst_i || !trst_n) begin
			state_q <= jtag_pkg::TAP_RESET;
		end else if (tck_rise) begin
			state_q <= state_d;
		end
	end

	always_comb begin
		strobe_o            = '0;
		strobe_o.dr_capture = tck_rise && (state_q == jtag_pkg::TAP_CAP_DR);
		strobe_o.dr_shift   = tck_rise && (state_q == jtag_pkg::TAP_SHIFT_DR);
		strobe_o.dr_update  = tck_rise && (state_q == jtag_pkg::TAP_UPD_DR);
		strobe_o.ir_capture = tck_rise && (state_q == jtag_pkg::TAP_CAP_IR);
		strobe_o.ir_shift   = tck_rise && (state_q == jtag_pkg::TAP_SHIFT_IR);
		strobe_o.ir_update  = tck_rise && (state_q == jtag_pkg::TAP_UPD_IR);
	end

	always_ff @(posedge clk) begin
		if (strobe_o.ir_capture) begin
			ir_sr <= jtag_pkg::IR_CAPTURE_VALUE;
		end else if (strobe_o.ir_shift) begin
			ir_sr <= {tdi_o, ir_sr[jtag_pkg::IR_WIDTH-1:1]};
		end
	end

	// IDCODE is the default whenever the TAP sits in Test-Logic-Reset
	always_ff @(posedge clk) begin
		if (rst_i || !trst_n || (state_q == jtag_pkg::TAP_RESET)) begin
			instr_o <= jtag_pkg::IDCODE;
		end else if (strobe_o.ir_update) begin
			instr_o <= jtag_pkg::jtag_instr_e'(ir_sr);
		end
	end

	always_ff @(posedge clk) begin
		if (rst_i || !trst_n) begin
			tdo_o <= 1'b0;
		end else if (tck_fall) begin
			case (state_q)
				jtag_pkg::TAP_SHIFT_IR: tdo_o <= ir_sr[0];
				jtag_pkg::TAP_SHIFT_DR: tdo_o <= dr_tdo_i;
				default:                tdo_o <= 1'b0;
			endcase
		end
	end

endmodule

//--- common/debug_reg_pkg.sv
package debug_reg_pkg;

	localparam int REG_WIDTH          = 32;
	localparam int ADDR_WIDTH         = 8;
	localparam int GAIN_WIDTH         = 4;
	localparam int PI_CTL_WIDTH       = 9;
	localparam int CHAN_SEL_WIDTH     = 4;
	localparam int CHECKER_MODE_WIDTH = 2;

	typedef logic [REG_WIDTH-1:0]  reg_word_t;
	typedef logic [ADDR_WIDTH-1:0] reg_addr_t;

	// Writable registers
	localparam reg_addr_t ADDR_CTRL       = 8'h00;
	localparam reg_addr_t ADDR_IBUF       = 8'h01;
	localparam reg_addr_t ADDR_CDR_GAIN   = 8'h02;
	localparam reg_addr_t ADDR_CDR_PI     = 8'h03;
	localparam reg_addr_t ADDR_PRBS_CFG   = 8'h04;
	localparam reg_addr_t ADDR_PRBS_EQN   = 8'h05;

	// Status, read only
	localparam reg_addr_t ADDR_CDR_PHASE  = 8'h10;
	localparam reg_addr_t ADDR_PRBS_ERR   = 8'h11;
	localparam reg_addr_t ADDR_PRBS_TOTAL = 8'h12;

	// Field positions inside the register words
	localparam int KI_LSB           = 0;
	localparam int KP_LSB           = 4;
	localparam int KR_LSB           = 8;
	localparam int PI_EN_BIT        = 0;
	localparam int PI_CTL_LSB       = 1;
	localparam int PRBS_CKE_BIT     = 0;
	localparam int CHAN_SEL_LSB     = 1;
	localparam int CHECKER_MODE_LSB = 5;

	typedef struct packed {
		logic      en;
		reg_addr_t addr;
		reg_word_t data;
	} reg_write_t;

	typedef struct packed {
		logic int_rst;
		logic cdr_rst;
		logic prbs_rst;
		logic prbs_gen_rst;
	} block_rst_t;

	typedef struct packed {
		logic disable_async;
		logic disable_main;
		logic disable_mdll_ref;
		logic disable_mdll_mon;
	} ibuf_cfg_t;

	typedef struct packed {
		logic [GAIN_WIDTH-1:0]   ki;
		logic [GAIN_WIDTH-1:0]   kp;
		logic [GAIN_WIDTH-1:0]   kr;
		logic                    en_ext_pi_ctl;
		logic [PI_CTL_WIDTH-1:0] ext_pi_ctl;
	} cdr_cfg_t;

	typedef struct packed {
		logic                          cke;
		logic [CHAN_SEL_WIDTH-1:0]     chan_sel;
		logic [CHECKER_MODE_WIDTH-1:0] checker_mode;
		reg_word_t                     eqn;
	} prbs_cfg_t;

	typedef struct packed {
		reg_word_t phase_est;
	} cdr_status_t;

	typedef struct packed {
		reg_word_t err_bits;
		reg_word_t total_bits;
	} prbs_status_t;

endpackage

//--- common/jtag_pkg.sv
package jtag_pkg;

	localparam int IR_WIDTH = 5;

	// Device identification word, bit 0 fixed at 1 by IEEE 1149.1
	localparam logic [31:0] IDCODE_VALUE = 32'h1A5C_E3B1;

	// Value loaded into the IR on Capture-IR
	localparam logic [IR_WIDTH-1:0] IR_CAPTURE_VALUE = 5'b00001;

	typedef enum logic [IR_WIDTH-1:0] {
		IDCODE = 5'b00001,
		ADDR   = 5'b00010,
		DATA   = 5'b00011,
		BYPASS = 5'b11111
	} jtag_instr_e;

	// Standard TAP encoding
	typedef enum logic [3:0] {
		TAP_EXIT2_DR = 4'h0,
		TAP_EXIT1_DR = 4'h1,
		TAP_SHIFT_DR = 4'h2,
		TAP_PAUSE_DR = 4'h3,
		TAP_SEL_IR   = 4'h4,
		TAP_UPD_DR   = 4'h5,
		TAP_CAP_DR   = 4'h6,
		TAP_SEL_DR   = 4'h7,
		TAP_EXIT2_IR = 4'h8,
		TAP_EXIT1_IR = 4'h9,
		TAP_SHIFT_IR = 4'hA,
		TAP_PAUSE_IR = 4'hB,
		TAP_IDLE     = 4'hC,
		TAP_UPD_IR   = 4'hD,
		TAP_CAP_IR   = 4'hE,
		TAP_RESET    = 4'hF
	} tap_state_e;

	// One clk wide, on the tck rising edge seen in the named state
	typedef struct packed {
		logic dr_capture;
		logic dr_shift;
		logic dr_update;
		logic ir_capture;
		logic ir_shift;
		logic ir_update;
	} tap_strobe_t;

endpackage
